// File: source/arb_pkg.sv
// Shared types and default sizes for the matrix arbiter.
// Import with arb_pkg::* in any module header that needs the state enums
// or the default ROWS/COLS/POLARITY values.
package arb_pkg;

    // Four-phase handshake tracking in the decode stage
    typedef enum logic [1:0] {
        HS_IDLE = 2'b00,  // Waiting for start_req_i
        HS_BUSY = 2'b01,  // Request in flight, waiting for ack
        HS_HOLD = 2'b10   // Ack given, waiting for start_req_i to drop
    } hs_state_t;

    // Row group status held by the execute stage
    typedef enum logic {
        GROUP_CLOSED = 1'b0,  // Next grant picks a fresh row
        GROUP_OPEN   = 1'b1   // Columns of the current row still being served
    } group_state_t;

    // Default matrix geometry
    localparam int ROWS_DEFAULT = 8;  // Rows in the request matrix
    localparam int COLS_DEFAULT = 8;  // Columns per row
    localparam int POL_DEFAULT  = 2;  // Request lanes per cell

endpackage

// File: source/req_decode.sv
`timescale 1ns/10ps
// Decode stage of the arbiter pipeline.
// Accepts one four-phase request at a time, freezes the request matrix
// for the whole transaction and reports which rows hold requests.
module req_decode import arb_pkg::*; #(
    parameter int  ROWS     = ROWS_DEFAULT,
    parameter int  COLS     = COLS_DEFAULT,
    parameter int  POLARITY = POL_DEFAULT,
    localparam int NREQ     = ROWS * COLS * POLARITY
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            start_req_i,   // Four-phase request
    input  logic [NREQ-1:0] req_i,         // Flattened request matrix
    input  logic            res_ack_i,     // Level of ack_o from the result stage
    output logic            dec_valid_o,   // One-cycle pulse, snapshot ready
    output logic [NREQ-1:0] snap_req_o,    // Frozen request matrix
    output logic [ROWS-1:0] row_active_o,  // Per-row OR of the snapshot
    output logic            hs_release_o   // One-cycle pulse, clear the outputs
);

    localparam int ROW_BITS = COLS * POLARITY;  // Request bits per row

    hs_state_t       state_q, state_d;
    logic            capture;      // Take a snapshot this cycle
    logic            release_now;  // Requester has dropped start_req_i
    logic [ROWS-1:0] row_or;

    // Row activity straight from the live inputs, registered with the snapshot
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            row_or[r] = |req_i[r*ROW_BITS +: ROW_BITS];
        end
    end

    always_comb begin
        state_d     = state_q;
        capture     = 1'b0;
        release_now = 1'b0;
        case (state_q)
            HS_IDLE: begin
                if (start_req_i) begin
                    capture = 1'b1;
                    state_d = HS_BUSY;
                end
            end
            HS_BUSY: begin
                if (res_ack_i) state_d = HS_HOLD;  // Result stage has answered
            end
            HS_HOLD: begin
                if (!start_req_i) begin
                    release_now = 1'b1;
                    state_d     = HS_IDLE;
                end
            end
            default: state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= HS_IDLE;
            dec_valid_o  <= 1'b0;
            hs_release_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            dec_valid_o  <= capture;      // High for the cycle after E0
            hs_release_o <= release_now;
        end
    end

    // Matrix is held here until the next request, the requester may change req_i
    always_ff @(posedge clk_i) begin
        if (capture) begin
            snap_req_o   <= req_i;
            row_active_o <= row_or;
        end
    end

    // A decode pulse only ever follows an accepted request in idle
    a_dec_after_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_o |-> ($past(state_q) == HS_IDLE) && (state_q == HS_BUSY));

endmodule

// File: source/rr_row_arbiter.sv
`timescale 1ns/10ps
// Combinational round-robin row search.
// Returns the first active row found cyclically after row_ptr_i; the
// pointer row itself is checked last, so a lone active row is still found.
module rr_row_arbiter import arb_pkg::*; #(
    parameter int  ROWS = ROWS_DEFAULT,
    localparam int RW   = $clog2(ROWS)
) (
    input  logic [ROWS-1:0] row_active_i,  // Rows holding at least one request
    input  logic [RW-1:0]   row_ptr_i,     // Last row served
    output logic            row_found_o,   // Some row is active
    output logic [RW-1:0]   row_sel_o      // Next row in round-robin order
);

    always_comb begin
        int idx;
        idx         = 0;
        row_found_o = 1'b0;
        row_sel_o   = '0;
        for (int i = 1; i <= ROWS; i++) begin
            idx = (int'(row_ptr_i) + i) % ROWS;  // Wraps past ROWS-1 to row 0
            if (!row_found_o && row_active_i[idx]) begin
                row_found_o = 1'b1;
                row_sel_o   = RW'(idx);
            end
        end
    end

endmodule

// File: source/rr_col_arbiter.sv
`timescale 1ns/10ps
// Column search for the execute stage.
// While a row group is open, finds the next requesting column above the
// last one granted; once the row is exhausted, flags a group release and
// falls back to the lowest requesting column of the row arbiter's pick.
module rr_col_arbiter import arb_pkg::*; #(
    parameter int  ROWS     = ROWS_DEFAULT,
    parameter int  COLS     = COLS_DEFAULT,
    parameter int  POLARITY = POL_DEFAULT,
    localparam int RW       = $clog2(ROWS),
    localparam int CW       = $clog2(COLS),
    localparam int NREQ     = ROWS * COLS * POLARITY
) (
    input  logic [NREQ-1:0] snap_req_i,       // Frozen request matrix
    input  logic [RW-1:0]   row_i,            // Row of the open group
    input  logic [CW-1:0]   last_col_i,       // Column granted last in that row
    input  group_state_t    group_i,
    input  logic [RW-1:0]   new_row_i,        // Row arbiter candidate
    input  logic            new_row_found_i,
    output logic            col_found_o,
    output logic [CW-1:0]   col_sel_o,
    output logic            group_release_o   // Open row has nothing left above last_col_i
);

    logic [COLS-1:0]     cur_cols;   // Requesting columns of the open row
    logic [COLS-1:0]     new_cols;   // Requesting columns of the candidate row
    logic                cont_found;
    logic [CW-1:0]       cont_col;
    logic                new_found;
    logic [CW-1:0]       new_col;
    logic                use_cont;   // Stay inside the current group
    logic [RW-1:0]       sel_row;
    logic [POLARITY-1:0] sel_lanes;  // Lanes of the chosen cell

    // A column requests when any of its lanes is set
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            cur_cols[c] = |snap_req_i[(int'(row_i) * COLS + c) * POLARITY +: POLARITY];
            new_cols[c] = |snap_req_i[(int'(new_row_i) * COLS + c) * POLARITY +: POLARITY];
        end
    end

    // Lowest qualifying column in each row
    always_comb begin
        cont_found = 1'b0;
        cont_col   = '0;
        new_found  = 1'b0;
        new_col    = '0;
        for (int c = 0; c < COLS; c++) begin
            if (!cont_found && cur_cols[c] && (c > int'(last_col_i))) begin
                cont_found = 1'b1;
                cont_col   = CW'(c);
            end
            if (!new_found && new_cols[c]) begin
                new_found = 1'b1;
                new_col   = CW'(c);
            end
        end
    end

    assign use_cont        = (group_i == GROUP_OPEN) && cont_found;
    assign group_release_o = (group_i == GROUP_OPEN) && !cont_found;
    assign col_found_o     = use_cont || (new_row_found_i && new_found);
    assign col_sel_o       = use_cont ? cont_col : new_col;
    assign sel_row         = use_cont ? row_i : new_row_i;
    assign sel_lanes = snap_req_i[(int'(sel_row) * COLS + int'(col_sel_o)) * POLARITY +: POLARITY];

    // The reported cell must really be requesting in the snapshot
    always_comb begin
        if (col_found_o) begin
            a_cell_requests: assert final (|sel_lanes)
                else $error("column grant on a cell with no lane set");
        end
    end

endmodule

// File: source/arb_execute.sv
`timescale 1ns/10ps
// Execute stage of the arbiter pipeline.
// Keeps the round-robin state (row pointer, last column, group status),
// runs the row and column searches on each decoded request and registers
// the chosen cell together with its request lanes.
module arb_execute import arb_pkg::*; #(
    parameter int  ROWS     = ROWS_DEFAULT,
    parameter int  COLS     = COLS_DEFAULT,
    parameter int  POLARITY = POL_DEFAULT,
    localparam int RW       = $clog2(ROWS),
    localparam int CW       = $clog2(COLS),
    localparam int NREQ     = ROWS * COLS * POLARITY
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                dec_valid_i,   // Snapshot ready
    input  logic [NREQ-1:0]     snap_req_i,
    input  logic [ROWS-1:0]     row_active_i,
    output logic                exe_valid_o,   // One-cycle pulse to the result stage
    output logic                exe_hit_o,     // A cell was chosen
    output logic [RW-1:0]       exe_row_o,
    output logic [CW-1:0]       exe_col_o,
    output logic [POLARITY-1:0] exe_lanes_o    // Lanes of the chosen cell
);

    logic [RW-1:0] row_ptr_q;   // Row of the current or most recent group
    logic [CW-1:0] last_col_q;  // Last column granted in that row
    group_state_t  group_q;

    logic          row_found;
    logic [RW-1:0] row_sel;
    logic          col_found;
    logic [CW-1:0] col_sel;
    logic          group_release;
    logic          use_new;     // Leave the current row for the arbiter's pick
    logic [RW-1:0] pick_row;
    logic [POLARITY-1:0] pick_lanes;

    rr_row_arbiter #(
        .ROWS(ROWS)
    ) u_row_arb (
        .row_active_i(row_active_i),
        .row_ptr_i   (row_ptr_q),
        .row_found_o (row_found),
        .row_sel_o   (row_sel)
    );

    rr_col_arbiter #(
        .ROWS    (ROWS),
        .COLS    (COLS),
        .POLARITY(POLARITY)
    ) u_col_arb (
        .snap_req_i     (snap_req_i),
        .row_i          (row_ptr_q),
        .last_col_i     (last_col_q),
        .group_i        (group_q),
        .new_row_i      (row_sel),
        .new_row_found_i(row_found),
        .col_found_o    (col_found),
        .col_sel_o      (col_sel),
        .group_release_o(group_release)
    );

    assign use_new    = (group_q == GROUP_CLOSED) || group_release;
    assign pick_row   = use_new ? row_sel : row_ptr_q;
    assign pick_lanes = snap_req_i[(int'(pick_row) * COLS + int'(col_sel)) * POLARITY +: POLARITY];

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            row_ptr_q   <= RW'(ROWS - 1);  // First search starts at row 0
            last_col_q  <= '0;
            group_q     <= GROUP_CLOSED;
            exe_valid_o <= 1'b0;
            exe_hit_o   <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
            exe_hit_o   <= dec_valid_i && col_found;
            if (dec_valid_i && col_found) begin  // Empty matrix leaves the state alone
                row_ptr_q  <= pick_row;
                last_col_q <= col_sel;
                group_q    <= GROUP_OPEN;
            end
        end
    end

    // Chosen cell travels with the valid pulse
    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            exe_row_o   <= pick_row;
            exe_col_o   <= col_sel;
            exe_lanes_o <= pick_lanes;
        end
    end

endmodule

// File: source/grant_result.sv
`timescale 1ns/10ps
// Result stage of the arbiter pipeline.
// Turns the chosen cell into one-hot row and column grants plus the
// lowest requesting lane, raises ack_o and clears everything on release.
module grant_result import arb_pkg::*; #(
    parameter int  ROWS     = ROWS_DEFAULT,
    parameter int  COLS     = COLS_DEFAULT,
    parameter int  POLARITY = POL_DEFAULT,
    localparam int RW       = $clog2(ROWS),
    localparam int CW       = $clog2(COLS),
    localparam int PW       = (POLARITY > 1) ? $clog2(POLARITY) : 1
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                exe_valid_i,
    input  logic                exe_hit_i,
    input  logic [RW-1:0]       exe_row_i,
    input  logic [CW-1:0]       exe_col_i,
    input  logic [POLARITY-1:0] exe_lanes_i,
    input  logic                hs_release_i,  // Requester has dropped start_req_i
    output logic                ack_o,
    output logic                gnt_valid_o,
    output logic [ROWS-1:0]     row_gnt_o,
    output logic [COLS-1:0]     col_gnt_o,
    output logic [PW-1:0]       polarity_o
);

    logic [PW-1:0] low_lane;  // Index of the lowest set lane

    // Scan downwards so the lowest set lane is written last
    always_comb begin
        low_lane = '0;
        for (int p = POLARITY - 1; p >= 0; p--) begin
            if (exe_lanes_i[p]) low_lane = PW'(p);
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            ack_o       <= 1'b0;
            gnt_valid_o <= 1'b0;
            row_gnt_o   <= '0;
            col_gnt_o   <= '0;
            polarity_o  <= '0;
        end else if (hs_release_i) begin
            ack_o       <= 1'b0;  // Ends the four-phase cycle
            gnt_valid_o <= 1'b0;
            row_gnt_o   <= '0;
            col_gnt_o   <= '0;
            polarity_o  <= '0;
        end else if (exe_valid_i) begin
            ack_o       <= 1'b1;  // Acked even for an empty matrix
            gnt_valid_o <= exe_hit_i;
            row_gnt_o   <= exe_hit_i ? (ROWS'(1) << exe_row_i) : '0;
            col_gnt_o   <= exe_hit_i ? (COLS'(1) << exe_col_i) : '0;
            polarity_o  <= exe_hit_i ? low_lane : '0;
        end
    end

    // A valid grant always names exactly one row and one column
    a_onehot_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        (ack_o && gnt_valid_o) |-> ($onehot(row_gnt_o) && $onehot(col_gnt_o)));

endmodule

// File: source/matrix_arb_top.sv
`timescale 1ns/10ps
// Two-level round-robin matrix arbiter.
// Request matrix in, one cell grant per four-phase start_req_i/ack_o cycle.
// Pipeline is decode -> execute -> result, ack_o two cycles after the start.
module matrix_arb_top import arb_pkg::*; #(
    parameter int  ROWS     = ROWS_DEFAULT,
    parameter int  COLS     = COLS_DEFAULT,
    parameter int  POLARITY = POL_DEFAULT,
    localparam int RW       = $clog2(ROWS),
    localparam int CW       = $clog2(COLS),
    localparam int PW       = (POLARITY > 1) ? $clog2(POLARITY) : 1,
    localparam int NREQ     = ROWS * COLS * POLARITY
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [NREQ-1:0] req_i,        // Bit (r*COLS+c)*POLARITY+p
    input  logic            start_req_i,
    output logic            ack_o,
    output logic            gnt_valid_o,  // Low when the matrix was empty
    output logic [ROWS-1:0] row_gnt_o,
    output logic [COLS-1:0] col_gnt_o,
    output logic [PW-1:0]   polarity_o
);

    logic                dec_valid;
    logic [NREQ-1:0]     snap_req;
    logic [ROWS-1:0]     row_active;
    logic                hs_release;
    logic                exe_valid;
    logic                exe_hit;
    logic [RW-1:0]       exe_row;
    logic [CW-1:0]       exe_col;
    logic [POLARITY-1:0] exe_lanes;

    req_decode #(.ROWS(ROWS), .COLS(COLS), .POLARITY(POLARITY)) u_decode (
        .clk_i(clk_i), .reset_i(reset_i),
        .start_req_i (start_req_i),
        .req_i       (req_i),
        .res_ack_i   (ack_o),           // Ack level closes the busy phase
        .dec_valid_o (dec_valid),
        .snap_req_o  (snap_req),
        .row_active_o(row_active),
        .hs_release_o(hs_release)
    );

    arb_execute #(.ROWS(ROWS), .COLS(COLS), .POLARITY(POLARITY)) u_execute (
        .clk_i(clk_i), .reset_i(reset_i),
        .dec_valid_i (dec_valid),
        .snap_req_i  (snap_req),
        .row_active_i(row_active),
        .exe_valid_o (exe_valid),
        .exe_hit_o   (exe_hit),
        .exe_row_o   (exe_row),
        .exe_col_o   (exe_col),
        .exe_lanes_o (exe_lanes)
    );

    grant_result #(.ROWS(ROWS), .COLS(COLS), .POLARITY(POLARITY)) u_result (
        .clk_i(clk_i), .reset_i(reset_i),
        .exe_valid_i (exe_valid),
        .exe_hit_i   (exe_hit),
        .exe_row_i   (exe_row),
        .exe_col_i   (exe_col),
        .exe_lanes_i (exe_lanes),
        .hs_release_i(hs_release),
        .ack_o       (ack_o),
        .gnt_valid_o (gnt_valid_o),
        .row_gnt_o   (row_gnt_o),
        .col_gnt_o   (col_gnt_o),
        .polarity_o  (polarity_o)
    );

endmodule

// File: test/tb_matrix_arb.sv
`timescale 1ns/10ps
// Random-stimulus testbench for matrix_arb_top at the default sizes.
// A round-robin model predicts every grant, and each four-phase handshake
// is checked for its grant values, the ack latency and the release timing.
module tb_matrix_arb import arb_pkg::*; ();

    localparam int ROWS         = ROWS_DEFAULT;
    localparam int COLS         = COLS_DEFAULT;
    localparam int POLARITY     = POL_DEFAULT;
    localparam int NREQ         = ROWS * COLS * POLARITY;
    localparam int PW           = (POLARITY > 1) ? $clog2(POLARITY) : 1;
    localparam int SEED         = 47526;
    localparam int ACK_TIMEOUT  = 20;    // Negedges allowed per handshake phase
    localparam int ACK_RISE_LAT = 3;     // Low negedges counted from the one before E0
    localparam int ACK_FALL_LAT = 2;     // High negedges after start_req_i drops
    localparam int RANDOM_RUNS  = 2000;

    logic            clk_i;
    logic            reset_i;
    logic [NREQ-1:0] req_i;
    logic            start_req_i;
    logic            ack_o;
    logic            gnt_valid_o;
    logic [ROWS-1:0] row_gnt_o;
    logic [COLS-1:0] col_gnt_o;
    logic [PW-1:0]   polarity_o;

    int        m_row_ptr;     // Model row pointer
    int        m_last_col;    // Model last granted column
    bit        m_group_open;
    int        exp_hit;
    int        exp_row;
    int        exp_col;
    int        exp_pol;
    hs_state_t phase;         // Handshake phase, for messages

    matrix_arb_top #(.ROWS(ROWS), .COLS(COLS), .POLARITY(POLARITY)) dut_i (
        .clk_i(clk_i), .reset_i(reset_i),
        .req_i      (req_i),
        .start_req_i(start_req_i),
        .ack_o      (ack_o),
        .gnt_valid_o(gnt_valid_o),
        .row_gnt_o  (row_gnt_o),
        .col_gnt_o  (col_gnt_o),
        .polarity_o (polarity_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;  // 100 ns period
    end

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // Start bit of cell (r, c) in the flattened matrix
    function automatic int bit_pos(input int r, input int c);
        return (r * COLS + c) * POLARITY;
    endfunction

    function automatic logic [POLARITY-1:0] lanes_of(input logic [NREQ-1:0] m,
                                                    input int r, input int c);
        return m[bit_pos(r, c) +: POLARITY];
    endfunction

    // Kind 0 empty, 1 single cell, 2 sparse, 3 dense
    function automatic logic [NREQ-1:0] random_matrix(input int kind);
        logic [NREQ-1:0]     m;
        logic [POLARITY-1:0] lanes;
        int                  r;
        int                  c;
        m = '0;
        if (kind == 1) begin
            r     = int'($urandom % ROWS);
            c     = int'($urandom % COLS);
            lanes = POLARITY'($urandom);
            if (lanes == '0) lanes[int'($urandom % POLARITY)] = 1'b1;  // Never an empty cell
            m[bit_pos(r, c) +: POLARITY] = lanes;
        end else if (kind == 2) begin
            for (int b = 0; b < NREQ; b++) m[b] = (($urandom % 16) == 0);
        end else if (kind == 3) begin
            for (int b = 0; b < NREQ; b++) m[b] = (($urandom % 4) != 0);
        end
        return m;
    endfunction

    // Three active rows where the last one forces a wrap back to row 1
    function automatic logic [NREQ-1:0] fixed_matrix();
        logic [NREQ-1:0] m;
        m = '0;
        m[bit_pos(1, 0) +: POLARITY]               = POLARITY'(1);
        m[bit_pos(1, 3) +: POLARITY]               = POLARITY'(2);
        m[bit_pos(1, COLS - 2) +: POLARITY]        = POLARITY'(3);
        m[bit_pos(ROWS / 2, 2) +: POLARITY]        = POLARITY'(2);
        m[bit_pos(ROWS - 1, 1) +: POLARITY]        = POLARITY'(1);
        m[bit_pos(ROWS - 1, COLS - 1) +: POLARITY] = POLARITY'(2);
        return m;
    endfunction

    // Finish the open row upwards or else take the next active row
    task automatic predict(input logic [NREQ-1:0] m);
        int                  r;
        int                  c;
        int                  i;
        int                  p;
        bit                  found;
        logic [POLARITY-1:0] lanes;
        found   = 1'b0;
        exp_hit = 0;
        exp_row = 0;
        exp_col = 0;
        exp_pol = 0;
        if (m_group_open) begin
            for (c = m_last_col + 1; c < COLS && !found; c++) begin
                if (|lanes_of(m, m_row_ptr, c)) begin
                    found   = 1'b1;
                    exp_row = m_row_ptr;
                    exp_col = c;
                end
            end
        end
        for (i = 1; i <= ROWS && !found; i++) begin
            r = (m_row_ptr + i) % ROWS;  // Pointer row is searched last
            for (c = 0; c < COLS && !found; c++) begin
                if (|lanes_of(m, r, c)) begin
                    found   = 1'b1;
                    exp_row = r;
                    exp_col = c;
                end
            end
        end
        if (found) begin
            exp_hit = 1;
            lanes   = lanes_of(m, exp_row, exp_col);
            for (p = POLARITY - 1; p >= 0; p--) begin
                if (lanes[p]) exp_pol = p;  // Lowest set lane wins
            end
            m_row_ptr    = exp_row;
            m_last_col   = exp_col;
            m_group_open = 1'b1;
        end
    endtask

    task automatic check_idle();
        check_value("ack_o", int'(ack_o), 0);
        check_value("gnt_valid_o", int'(gnt_valid_o), 0);
        check_value("row_gnt_o", int'(row_gnt_o), 0);
        check_value("col_gnt_o", int'(col_gnt_o), 0);
        check_value("polarity_o", int'(polarity_o), 0);
    endtask

    task automatic check_grant();
        check_value("ack_o", int'(ack_o), 1);
        check_value("gnt_valid_o", int'(gnt_valid_o), exp_hit);
        check_value("row_gnt_o", int'(row_gnt_o), (exp_hit != 0) ? (1 << exp_row) : 0);
        check_value("col_gnt_o", int'(col_gnt_o), (exp_hit != 0) ? (1 << exp_col) : 0);
        check_value("polarity_o", int'(polarity_o), (exp_hit != 0) ? exp_pol : 0);
    endtask

    // One full four-phase cycle with a random hold time
    task automatic run_handshake(input logic [NREQ-1:0] m);
        int lat;
        int hold;
        hold = int'($urandom % 5);
        @(posedge clk_i);
        #1;
        req_i       = m;
        start_req_i = 1'b1;
        phase       = HS_BUSY;
        predict(m);
        lat = 0;
        @(negedge clk_i);
        while (!ack_o && lat < ACK_TIMEOUT) begin
            check_idle();
            lat++;
            @(negedge clk_i);
        end
        if (!ack_o) begin
            $display("Timeout at %0t: ack_o never rose in %s", $time, phase.name());
            end_with_failure();
        end
        check_value("ack_rise_cycles", lat, ACK_RISE_LAT);
        phase = HS_HOLD;
        check_grant();
        repeat (hold) begin
            @(negedge clk_i);
            check_grant();                 // Back-pressure keeps the grant
        end
        @(posedge clk_i);
        #1;
        start_req_i = 1'b0;
        req_i       = random_matrix(3);    // Snapshot is already taken
        lat = 0;
        @(negedge clk_i);
        while (ack_o && lat < ACK_TIMEOUT) begin
            check_grant();
            lat++;
            @(negedge clk_i);
        end
        if (ack_o) begin
            $display("Timeout at %0t: ack_o never fell in %s", $time, phase.name());
            end_with_failure();
        end
        check_value("ack_fall_cycles", lat, ACK_FALL_LAT);
        check_idle();
        phase = HS_IDLE;
    endtask

    initial begin
        int k;
        void'($urandom(SEED));
        phase        = HS_IDLE;
        m_row_ptr    = ROWS - 1;           // First search starts at row 0
        m_last_col   = 0;
        m_group_open = 1'b0;
        reset_i      = 1'b1;
        start_req_i  = 1'b0;
        req_i        = '0;
        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        @(negedge clk_i);
        check_idle();
        repeat (14) run_handshake(fixed_matrix());  // Columns ascend and rows wrap
        repeat (3) run_handshake('0);               // Empty matrix leaves the pointers alone
        repeat (4) run_handshake(fixed_matrix());
        repeat (200) run_handshake(random_matrix(1));
        repeat (RANDOM_RUNS) begin
            k = int'($urandom % 8);
            if (k == 0) run_handshake(random_matrix(0));
            else if (k < 3) run_handshake(random_matrix(1));
            else if (k < 6) run_handshake(random_matrix(2));
            else run_handshake(random_matrix(3));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: filelist.f
source/arb_pkg.sv
source/req_decode.sv
source/rr_row_arbiter.sv
source/rr_col_arbiter.sv
source/arb_execute.sv
source/grant_result.sv
source/matrix_arb_top.sv
test/tb_matrix_arb.sv

// File: Makefile
# Verilator build and run for the matrix arbiter testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run tb_matrix_arb"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -sv -f filelist.f \
		--top-module tb_matrix_arb -Mdir $(OBJ_DIR) -o sim_tb_matrix_arb
	./$(OBJ_DIR)/sim_tb_matrix_arb

clean:
	rm -rf $(OBJ_DIR)
